// ==== hdl/alu_pkg.sv ====
package alu_pkg;

    // ----------------------------------------
    // Operation codes
    // ----------------------------------------
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_neg  = 4'd2,    // Two's complement of A
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_slt  = 4'd6,    // Signed A < B
        op_sltu = 4'd7,    // Unsigned A < B
        op_ne   = 4'd8,    // A != B
        op_sll  = 4'd9,
        op_srl  = 4'd10,
        op_sra  = 4'd11    // Sign fill
    } alu_op_e;            // 12..15 undefined, result zero

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam int addr_width = 5;    // Byte offsets 0x00..0x1F

    typedef enum logic [addr_width-1:0] {
        reg_opa    = 5'h00,    // RW
        reg_opb    = 5'h04,    // RW
        reg_op     = 5'h08,    // RW, write launches
        reg_result = 5'h0C,    // RO
        reg_status = 5'h10     // RO
    } reg_addr_e;

    // Status word bit positions
    localparam int unsigned status_done     = 0;
    localparam int unsigned status_overflow = 1;

    // Single register access, one cycle wide
    typedef struct packed {
        logic                  valid;
        logic                  write;    // 1 = write, 0 = read
        logic [addr_width-1:0] addr;
        logic [63:0]           wdata;    // Low data_width bits used
    } reg_req_t;

    // Same-cycle answer from the register block
    typedef struct packed {
        logic [63:0] rdata;
        logic        err;    // Maps to SLVERR
    } reg_rsp_t;

endpackage

// ==== hdl/alu_adder.sv ====
module alu_adder #(
    parameter int data_width = 32
) (
    input  logic                  subtract,    // 1 = a - b
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    output logic [data_width-1:0] sum,
    output logic                  overflow     // Signed overflow
);

    logic [data_width-1:0] b_eff;    // b or ~b
    logic                  sign_a;
    logic                  sign_b;
    logic                  sign_s;

    // Subtract as a + ~b + 1
    assign b_eff = subtract ? ~b : b;
    assign sum   = a + b_eff + {{(data_width-1){1'b0}}, subtract};

    assign sign_a = a[data_width-1];
    assign sign_b = b_eff[data_width-1];
    assign sign_s = sum[data_width-1];

    // Same-sign inputs, result flipped sign
    assign overflow = (sign_a == sign_b) && (sign_s != sign_a);

endmodule

// ==== hdl/alu_core.sv ====
module alu_core import alu_pkg::*; #(
    parameter int data_width = 32
) (
    input  alu_op_e               op,
    input  logic [data_width-1:0] opa,
    input  logic [data_width-1:0] opb,
    output logic [data_width-1:0] res,
    output logic                  overflow
);

    localparam int shamt_width = $clog2(data_width);

    logic                   add_sub;     // Adder mode select
    logic [data_width-1:0]  add_sum;
    logic                   add_ovf;
    logic [shamt_width-1:0] shamt;       // Low bits of B only
    logic                   cmp_flag;    // Compare outcome, 1 bit
    logic                   sign_a;
    logic                   sign_b;

    assign shamt  = opb[shamt_width-1:0];
    assign sign_a = opa[data_width-1];
    assign sign_b = opb[data_width-1];

    // ----------------------------------------
    // Operation select
    // ----------------------------------------
    always_comb begin
        add_sub  = 1'b0;    // Defaults, most ops leave adder idle
        overflow = 1'b0;
        cmp_flag = 1'b0;
        res      = '0;
        case (op)
            op_add: begin
                res      = add_sum;
                overflow = add_ovf;
            end
            op_sub: begin
                add_sub  = 1'b1;
                res      = add_sum;
                overflow = add_ovf;
            end
            op_neg: res = -opa;    // 0 - A
            op_and: res = opa & opb;
            op_or:  res = opa | opb;
            op_xor: res = opa ^ opb;
            op_slt: begin
                add_sub = 1'b1;
                // Differing signs decide directly
                if (sign_a != sign_b) begin
                    cmp_flag = sign_a;
                end else begin
                    cmp_flag = add_sum[data_width-1];    // Sign of A - B
                end
                res = {{(data_width-1){1'b0}}, cmp_flag};
            end
            op_sltu: begin
                cmp_flag = (opa < opb);
                res      = {{(data_width-1){1'b0}}, cmp_flag};
            end
            op_ne: begin
                add_sub  = 1'b1;
                cmp_flag = |add_sum;    // Non-zero difference
                res      = {{(data_width-1){1'b0}}, cmp_flag};
            end
            op_sll: res = opa << shamt;
            op_srl: res = opa >> shamt;    // Zero fill
            op_sra: res = $unsigned($signed(opa) >>> shamt);
            default: res = '0;    // Codes 12..15
        endcase
    end

    // ----------------------------------------
    // Shared add/subtract
    // ----------------------------------------
    alu_adder #(
        .data_width (data_width)
    ) adder_inst0 (
        .subtract   (add_sub),
        .a          (opa),
        .b          (opb),
        .sum        (add_sum),
        .overflow   (add_ovf)
    );

endmodule

// ==== hdl/axil_slave.sv ====
module axil_slave import alu_pkg::*; #(
    parameter int data_width = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // Write address
    input  logic [addr_width-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    // Write data
    input  logic [data_width-1:0]   wdata,
    input  logic [data_width/8-1:0] wstrb,     // Partial strobes land whole
    input  logic                    wvalid,
    output logic                    wready,
    // Write response
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    // Read address
    input  logic [addr_width-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    // Read data
    output logic [data_width-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // Register block side
    output reg_req_t                req,
    input  reg_rsp_t                rsp
);

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    logic wr_acc;    // Write handshake this cycle
    logic rd_acc;    // Read handshake this cycle

    // ----------------------------------------
    // Acceptance and arbitration
    // ----------------------------------------
    // Address and data taken together, blocked while bvalid pending
    assign wr_acc = awvalid && wvalid && !bvalid;

    // Write wins a tie, read retried next cycle
    assign rd_acc = arvalid && !rvalid && !wr_acc;

    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign arready = rd_acc;

    // One request per accepted access
    always_comb begin
        req       = '0;
        req.valid = wr_acc || rd_acc;
        req.write = wr_acc;
        req.addr  = wr_acc ? awaddr : araddr;
        req.wdata[data_width-1:0] = wdata;
    end

    // ----------------------------------------
    // Response channels
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_acc) begin
                bvalid <= 1'b1;    // Next edge after handshake
            end else if (bready) begin
                bvalid <= 1'b0;    // Host took it
            end
            if (rd_acc) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload, captured with the handshake
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            bresp <= rsp.err ? resp_slverr : resp_okay;
        end
        if (rd_acc) begin
            rdata <= rsp.rdata[data_width-1:0];
            rresp <= rsp.err ? resp_slverr : resp_okay;
        end
    end

endmodule

// ==== hdl/alu_regs.sv ====
module alu_regs import alu_pkg::*; #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  reg_req_t              req,
    output reg_rsp_t              rsp,
    // To the core
    output logic [data_width-1:0] opa,
    output logic [data_width-1:0] opb,
    output alu_op_e               op,
    // From the core
    input  logic [data_width-1:0] res,
    input  logic                  overflow
);

    logic [data_width-1:0] opa_q;
    logic [data_width-1:0] opb_q;
    alu_op_e               op_q;
    logic [data_width-1:0] result_q;
    logic                  ovf_q;       // Status overflow
    logic                  done_q;      // Status done
    logic                  launch_q;    // One cycle after reg_op write

    logic [data_width-1:0] rd_word;
    logic                  err;
    logic                  wr_en;

    // ----------------------------------------
    // Offset decode and read mux
    // ----------------------------------------
    always_comb begin
        err     = 1'b0;
        rd_word = '0;
        case (req.addr)
            reg_opa: rd_word = opa_q;
            reg_opb: rd_word = opb_q;
            reg_op:  rd_word[3:0] = op_q;    // Zero-extended code
            reg_result: begin
                rd_word = result_q;
                err     = req.write;    // Read-only
            end
            reg_status: begin
                rd_word[status_done]     = done_q;
                rd_word[status_overflow] = ovf_q;
                err                      = req.write;
            end
            default: err = 1'b1;    // Unmapped or unaligned
        endcase
    end

    always_comb begin
        rsp                       = '0;
        rsp.rdata[data_width-1:0] = rd_word;
        rsp.err                   = err;
    end

    // Errored writes change nothing
    assign wr_en = req.valid && req.write && !err;

    // ----------------------------------------
    // Registers, launch and capture
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            opa_q    <= '0;
            opb_q    <= '0;
            op_q     <= op_add;    // Code 0
            result_q <= '0;
            ovf_q    <= 1'b0;
            done_q   <= 1'b0;
            launch_q <= 1'b0;
        end else begin
            launch_q <= 1'b0;
            if (wr_en) begin
                case (req.addr)
                    reg_opa: begin
                        opa_q  <= req.wdata[data_width-1:0];
                        done_q <= 1'b0;    // Result now stale
                    end
                    reg_opb: begin
                        opb_q  <= req.wdata[data_width-1:0];
                        done_q <= 1'b0;
                    end
                    reg_op: begin
                        op_q     <= alu_op_e'(req.wdata[3:0]);
                        launch_q <= 1'b1;
                    end
                    default: ;
                endcase
            end
            // Operands and code already settled
            if (launch_q) begin
                result_q <= res;
                ovf_q    <= overflow;
                done_q   <= 1'b1;
            end
        end
    end

    assign opa = opa_q;
    assign opb = opb_q;
    assign op  = op_q;

endmodule

// ==== hdl/alu_top.sv ====
module alu_top import alu_pkg::*; #(
    parameter int data_width = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // AXI4-Lite slave
    input  logic [addr_width-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [data_width-1:0]   wdata,
    input  logic [data_width/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [addr_width-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [data_width-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready
);

    reg_req_t              req;    // Slave to register block
    reg_rsp_t              rsp;
    logic [data_width-1:0] opa;    // Register block to core
    logic [data_width-1:0] opb;
    alu_op_e               op;
    logic [data_width-1:0] res;    // Core back to register block
    logic                  overflow;

    // ----------------------------------------
    // Bus front end
    // ----------------------------------------
    axil_slave #(
        .data_width (data_width)
    ) slave_inst0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .req     (req),
        .rsp     (rsp)
    );

    // Register block steers the core
    alu_regs #(
        .data_width (data_width)
    ) regs_inst0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .rsp      (rsp),
        .opa      (opa),
        .opb      (opb),
        .op       (op),
        .res      (res),
        .overflow (overflow)
    );

    alu_core #(
        .data_width (data_width)
    ) core_inst0 (
        .op       (op),
        .opa      (opa),
        .opb      (opb),
        .res      (res),
        .overflow (overflow)
    );

endmodule

// ==== tb/alu_chk.sv ====
module alu_chk import alu_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     awready,
    input logic     wready,
    input logic     arready,
    input logic     bvalid,
    input logic     bready,
    input logic     rvalid,
    input logic     rready,
    input reg_req_t req,
    input logic     done    // Status done bit
);

    int fail_count = 0;    // Failed assertions so far

    // ----------------------------------------
    // Response channels hold until taken
    // ----------------------------------------
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    // Bus quiet on the first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !(awready || wready || arready || bvalid || rvalid))
        else begin
            fail_count++;
            $error("ready or valid high right after reset");
        end

    // Launch flag one edge after the request, done the edge after that
    launch_done: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid && req.write && (req.addr == reg_op) |=> ##1 done)
        else begin
            fail_count++;
            $error("done not set two cycles after operation write");
        end

endmodule

bind alu_top alu_chk chk0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .awready (awready),
    .wready  (wready),
    .arready (arready),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready),
    .req     (req),
    .done    (regs_inst0.done_q)
);

// ==== tb/tb_top.sv ====
module tb_top import alu_pkg::*; ();

    localparam int dw    = 32;
    localparam int limit = 50;    // Cycles allowed per handshake wait

    logic                  clk;
    logic                  rst_n;
    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [dw-1:0]         wdata;
    logic [dw/8-1:0]       wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [dw-1:0]         rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    logic [31:0] seed;        // LCG state
    int          errors;      // Value mismatches so far
    int          tests_ok;
    int          tests_bad;
    event        abort_ev;    // Raised by a stuck handshake

    alu_top #(.data_width(dw)) dut0 (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Expected {overflow, result} from the operation rules
    function automatic logic [32:0] model_op(input logic [3:0] code, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [31:0] r;
        logic        v;
        r = '0;
        v = 1'b0;
        case (code)
            op_add: begin
                r = a + b;
                v = (a[31] == b[31]) && (r[31] != a[31]);    // Like signs, flipped result
            end
            op_sub: begin
                r = a - b;
                v = (a[31] != b[31]) && (r[31] != a[31]);
            end
            op_neg:  r = 32'd0 - a;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_slt:  r = {31'd0, $signed(a) < $signed(b)};
            op_sltu: r = {31'd0, a < b};
            op_ne:   r = {31'd0, a != b};
            op_sll:  r = a << b[4:0];    // Low five bits only
            op_srl:  r = a >> b[4:0];
            op_sra:  r = (a >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'd0);
            default: r = '0;             // Undefined codes
        endcase
        return {v, r};
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout: no %s within %0d cycles", what, limit);
        -> abort_ev;
        forever @(posedge clk);    // Abort process ends the run
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // ----------------------------------------
    // AXI4-Lite host tasks
    // ----------------------------------------
    // Entered 1 unit after a rising edge; stall holds bready low
    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data, input int stall,
                              input logic [1:0] exp_resp);
        int n;
        n       = 0;
        awaddr  = addr;
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready)) begin
            n++;
            if (n > limit) report_timeout("write address/data handshake");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (stall) begin    // Back-pressure on B
            @(posedge clk);
            #1;
        end
        bready = 1'b1;
        n      = 0;
        @(negedge clk);
        while (!bvalid) begin
            n++;
            if (n > limit) report_timeout("write response");
            @(negedge clk);
        end
        check($sformatf("bresp at %h", addr), {30'd0, exp_resp}, {30'd0, bresp});
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] addr, input int stall, input logic [1:0] exp_resp,
                             output logic [31:0] data);
        int n;
        n       = 0;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) begin
            n++;
            if (n > limit) report_timeout("read address handshake");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        repeat (stall) begin    // Back-pressure on R
            @(posedge clk);
            #1;
        end
        rready = 1'b1;
        n      = 0;
        @(negedge clk);
        while (!rvalid) begin
            n++;
            if (n > limit) report_timeout("read data");
            @(negedge clk);
        end
        data = rdata;
        check($sformatf("rresp at %h", addr), {30'd0, exp_resp}, {30'd0, rresp});
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // One full launch and readback
    task automatic run_op(input logic [3:0] code, input logic [31:0] a, input logic [31:0] b,
                          input int stall);
        logic [32:0] exp;
        logic [31:0] exp_st;
        logic [31:0] got;
        exp                     = model_op(code, a, b);
        exp_st                  = '0;
        exp_st[status_done]     = 1'b1;
        exp_st[status_overflow] = exp[32];
        axil_write(reg_opa, a, 0, 2'b00);
        axil_write(reg_opb, b, stall, 2'b00);
        axil_write(reg_op, {28'd0, code}, 0, 2'b00);
        axil_read(reg_result, stall, 2'b00, got);
        check($sformatf("reg_result op %0d", code), exp[31:0], got);
        axil_read(reg_status, 0, 2'b00, got);
        check($sformatf("reg_status op %0d", code), exp_st, got);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d mismatches", name, errors - errs_before);
        end
    endtask

    initial begin
        @(abort_ev);
        $display("Simulation FAILED");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int          e0;
        logic [31:0] v;
        logic [31:0] snap[5];
        logic [31:0] ea[6];
        logic [31:0] eb[6];
        logic [4:0]  regs[5];
        string       names[5];
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        seed      = 32'd66;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        regs  = '{reg_opa, reg_opb, reg_op, reg_result, reg_status};
        names = '{"reg_opa", "reg_opb", "reg_op", "reg_result", "reg_status"};
        // Edge pairs, incl. overflow corners and shift by 0 and 31
        ea = '{32'h0, 32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF};
        eb = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h0000_0001, 32'd31, 32'd0};
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);    // Bus idle on the first cycle out of reset
        #1;

        e0 = errors;
        foreach (regs[i]) begin
            axil_read(regs[i], 0, 2'b00, v);
            check(names[i], 32'd0, v);
        end
        end_test("reset values", e0);

        e0 = errors;
        for (int c = 0; c < 12; c++) begin
            foreach (ea[i]) run_op(c[3:0], ea[i], eb[i], i % 3);
            run_op(c[3:0], next_rand(), 32'd0, 0);
            run_op(c[3:0], next_rand(), 32'd31, 1);
            for (int k = 0; k < 4; k++) run_op(c[3:0], next_rand(), next_rand(), k);
        end
        end_test("all operations", e0);

        e0 = errors;
        for (int c = 12; c < 16; c++) run_op(c[3:0], next_rand(), next_rand(), 0);
        end_test("undefined codes", e0);

        e0 = errors;
        foreach (regs[i]) axil_read(regs[i], 0, 2'b00, snap[i]);
        axil_write(reg_result, 32'h1234_5678, 0, 2'b10);
        axil_write(reg_status, 32'h0000_0003, 0, 2'b10);
        for (int a = 'h14; a < 32; a += 4) begin    // Unmapped tail of the map
            axil_write(a[4:0], next_rand(), 1, 2'b10);
            axil_read(a[4:0], 1, 2'b10, v);
        end
        foreach (regs[i]) begin
            axil_read(regs[i], 0, 2'b00, v);
            check(names[i], snap[i], v);
        end
        end_test("error responses", e0);

        e0 = errors;
        run_op(op_add, 32'd100, 32'd23, 0);
        axil_write(reg_opa, 32'd5, 0, 2'b00);
        axil_read(reg_status, 0, 2'b00, v);
        check("reg_status", 32'd0, v);             // Done cleared
        axil_read(reg_result, 2, 2'b00, v);
        check("reg_result", 32'd123, v);           // Old sum kept
        axil_write(reg_op, {28'd0, op_sub}, 0, 2'b00);
        axil_read(reg_result, 0, 2'b00, v);
        check("reg_result", 32'hFFFF_FFEE, v);     // 5 - 23
        end_test("done clear", e0);

        e0 = errors;
        axil_write(reg_opa, 32'hA5A5_0001, 0, 2'b00);
        axil_write(reg_opb, 32'h0F0F_0002, 0, 2'b00);
        fork
            begin
                axil_read(reg_opb, 6, 2'b00, v);
                check("reg_opb", 32'h0F0F_0002, v);
            end
            begin
                repeat (2) begin
                    @(posedge clk);
                    #1;
                end
                axil_write(reg_opa, 32'h1111_2222, 0, 2'b00);    // R still pending
            end
        join
        fork
            axil_write(reg_opb, 32'h3333_4444, 6, 2'b00);
            begin
                repeat (2) begin
                    @(posedge clk);
                    #1;
                end
                axil_read(reg_opa, 0, 2'b00, v);    // B still pending
                check("reg_opa", 32'h1111_2222, v);
            end
        join
        fork
            axil_write(reg_op, {28'd0, op_xor}, 3, 2'b00);    // Same cycle, write first
            axil_read(reg_opb, 3, 2'b00, v);
        join
        check("reg_opb", 32'h3333_4444, v);
        axil_read(reg_result, 0, 2'b00, v);
        check("reg_result", 32'h2222_6666, v);
        end_test("back-pressure and overlap", e0);

        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 tests_ok, tests_bad, dut0.chk0.fail_count);
        if (tests_bad == 0 && dut0.chk0.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/alu_pkg.sv
hdl/alu_adder.sv
hdl/alu_core.sv
hdl/axil_slave.sv
hdl/alu_regs.sv
hdl/alu_top.sv
tb/alu_chk.sv
tb/tb_top.sv

// ==== Bender.yml ====
package:
  name: alu_offload

sources:
  - hdl/alu_pkg.sv
  - hdl/alu_adder.sv
  - hdl/alu_core.sv
  - hdl/axil_slave.sv
  - hdl/alu_regs.sv
  - hdl/alu_top.sv
  - target: test
    files:
      - tb/alu_chk.sv
      - tb/tb_top.sv
